// File: design/lcmgr_pkg.sv
`default_nettype none

package lcmgr_pkg;

  //////////////////////////////////////////////////////////////////////
  // flash geometry
  //////////////////////////////////////////////////////////////////////

  localparam int BusWidth = 32;
  localparam int BusAddrW = 8;
  localparam int WordsPerPage = 4;
  localparam int PageW = 2;
  // num field of a request holds words minus one
  localparam int NumW = 2;

  // seeds
  localparam int NumSeeds = 2;
  localparam int SeedReads = 2;
  localparam int SeedIdxW = $clog2(NumSeeds);
  localparam int SeedRdW = $clog2(SeedReads);

  // info page of each seed, seed s is at word 0 of page SeedPage[s]
  localparam logic [NumSeeds-1:0][PageW-1:0] SeedPage = {2'd1, 2'd0};

  // rma wipe region
  localparam int ProgBurst = 2;
  localparam int WipeStartPage = 2;
  localparam int WipeNumPages = 2;
  localparam int WipeEndPage = WipeStartPage + WipeNumPages;
  localparam int PageCntW = $clog2(WipeEndPage + 1);
  localparam int WordCntW = $clog2(WordsPerPage + 1);
  localparam int BeatW = $clog2(ProgBurst);

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FlashOpRead,
    FlashOpProgram,
    FlashOpErase,
    FlashOpNone
  } flash_op_e;

  typedef struct packed {
    logic                start;
    flash_op_e           op;
    logic [BusAddrW-1:0] addr;
    logic [NumW-1:0]     num;
  } flash_req_t;

  typedef enum logic [1:0] {
    PhaseNone,
    PhaseSeed,
    PhaseRma
  } lcmgr_phase_e;

  // main life-cycle states
  typedef enum logic [2:0] {
    StIdle,
    StReadSeeds,
    StReadEval,
    StWait,
    StRmaWipe,
    StRmaRsp,
    StDisabled,
    StInvalid
  } lcmgr_state_e;

  // wipe sequencer states
  typedef enum logic [3:0] {
    StRmaIdle,
    StRmaPageSel,
    StRmaErase,
    StRmaEraseWait,
    StRmaWordSel,
    StRmaProgram,
    StRmaProgramWait,
    StRmaRdVerify,
    StRmaDisabled,
    StRmaInvalid
  } rma_state_e;

endpackage

`default_nettype wire

// File: design/lcmgr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lcmgr_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      init_i,
  input  logic                      provision_en_i,
  input  logic                      disable_i,
  input  logic                      rma_req_i,
  input  logic                      done_i,
  input  logic                      err_i,
  input  lcmgr_pkg::flash_req_t     seed_req_i,
  input  logic                      seeds_done_i,
  input  lcmgr_pkg::flash_req_t     rma_req_i_t,
  input  logic                      wipe_done_i,
  input  logic                      wipe_ok_i,
  output logic                      seed_run_o,
  output logic                      eval_step_o,
  output logic                      wipe_en_o,
  output lcmgr_pkg::flash_req_t     flash_req_o,
  output logic                      seed_err_o,
  output logic                      rma_ack_o,
  output logic                      dis_access_o,
  output logic                      fatal_err_o,
  output logic                      init_busy_o,
  output logic                      initialized_o,
  output lcmgr_pkg::lcmgr_phase_e   phase_o
);

  import lcmgr_pkg::*;

  lcmgr_state_e state_q, state_d;
  lcmgr_phase_e phase;
  logic         seed_err_q, seed_err_d;
  logic         rma_ack_q, rma_ack_d;
  logic         dis_access;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      seed_err_q <= 1'b0;
      rma_ack_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      seed_err_q <= seed_err_d;
      rma_ack_q  <= rma_ack_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    phase       = PhaseNone;
    seed_err_d  = seed_err_q;
    rma_ack_d   = 1'b0;
    seed_run_o  = 1'b0;
    eval_step_o = 1'b0;
    wipe_en_o   = 1'b0;
    dis_access  = 1'b0;

    case (state_q)
      // rma before init skips the seed reads
      StIdle: begin
        if (rma_req_i) begin
          state_d = StRmaWipe;
        end else if (init_i) begin
          state_d = provision_en_i ? StReadSeeds : StWait;
        end
      end

      StReadSeeds: begin
        phase      = PhaseSeed;
        seed_run_o = 1'b1;
        if (done_i) begin
          seed_err_d = seed_err_q | err_i;
          // last validate pass of last seed finishes the phase
          state_d    = seeds_done_i ? StWait : StReadEval;
        end
      end

      // one cycle gap between reads, reader flips pass or seed
      StReadEval: begin
        phase       = PhaseSeed;
        eval_step_o = 1'b1;
        state_d     = StReadSeeds;
      end

      StWait: begin
        if (rma_req_i) begin
          state_d = StRmaWipe;
        end
      end

      StRmaWipe: begin
        phase     = PhaseRma;
        wipe_en_o = 1'b1;
        if (wipe_done_i) begin
          state_d = wipe_ok_i ? StRmaRsp : StInvalid;
        end
      end

      // access stays blocked, ack follows the request
      StRmaRsp: begin
        phase      = PhaseRma;
        dis_access = 1'b1;
        rma_ack_d  = rma_req_i;
      end

      StDisabled: begin
        dis_access = 1'b1;
      end

      StInvalid: begin
        dis_access = 1'b1;
      end

      default: begin
        dis_access = 1'b1;
        state_d    = StInvalid;
      end
    endcase

    // disable wins, except over invalid or an ack in progress
    if (disable_i && (state_d != StInvalid) && !rma_ack_d) begin
      state_d = StDisabled;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // wiper keeps the bus outside the seed phase so an op in flight can end
  assign flash_req_o   = (phase == PhaseSeed) ? seed_req_i : rma_req_i_t;

  assign seed_err_o    = seed_err_q;
  assign rma_ack_o     = rma_ack_q;
  assign dis_access_o  = dis_access;
  assign fatal_err_o   = (state_q == StInvalid);
  assign init_busy_o   = (phase == PhaseSeed);
  assign initialized_o = (state_q == StWait);
  assign phase_o       = phase;

endmodule

`default_nettype wire

// File: design/lcmgr_seed_reader.sv
`timescale 1ns/1ps
`default_nettype none

module lcmgr_seed_reader (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 seed_run_i,
  input  logic                                 eval_step_i,
  input  logic                                 rvalid_i,
  input  logic [lcmgr_pkg::BusWidth-1:0]       rdata_i,
  output lcmgr_pkg::flash_req_t                seed_req_o,
  output logic                                 seeds_done_o,
  output logic [lcmgr_pkg::NumSeeds-1:0][lcmgr_pkg::SeedReads-1:0][lcmgr_pkg::BusWidth-1:0]
                                               seeds_o
);

  import lcmgr_pkg::*;

  logic [NumSeeds-1:0][SeedReads-1:0][BusWidth-1:0] seeds_q;
  logic [SeedIdxW-1:0] seed_idx_q;
  logic [SeedRdW-1:0]  rd_idx_q;
  logic                validate_q;
  logic                capture;
  logic [BusAddrW-1:0] seed_addr;

  assign capture = seed_run_i & rvalid_i;

  // word index per rvalid, pass flag and seed index per eval step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_idx_q   <= '0;
      seed_idx_q <= '0;
      validate_q <= 1'b0;
    end else if (eval_step_i) begin
      rd_idx_q   <= '0;
      validate_q <= ~validate_q;
      if (validate_q) begin
        seed_idx_q <= seed_idx_q + 1'b1;
      end
    end else if (capture) begin
      rd_idx_q <= rd_idx_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // seed capture
  //////////////////////////////////////////////////////////////////////

  // first pass stores, validate pass keeps only bits set in both reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seeds_q <= '0;
    end else if (capture && validate_q) begin
      seeds_q[seed_idx_q][rd_idx_q] <= seeds_q[seed_idx_q][rd_idx_q] & rdata_i;
    end else if (capture) begin
      seeds_q[seed_idx_q][rd_idx_q] <= rdata_i;
    end
  end

  // read starts at word 0 of the seed's info page
  assign seed_addr = BusAddrW'(SeedPage[seed_idx_q]) * BusAddrW'(WordsPerPage);

  always_comb begin
    seed_req_o.start = seed_run_i;
    seed_req_o.op    = FlashOpRead;
    seed_req_o.addr  = seed_addr;
    seed_req_o.num   = NumW'(SeedReads - 1);
  end

  // high during the validate pass of the last seed
  assign seeds_done_o = validate_q && (seed_idx_q == SeedIdxW'(NumSeeds - 1));
  assign seeds_o      = seeds_q;

endmodule

`default_nettype wire

// File: design/lcmgr_rma_wiper.sv
`timescale 1ns/1ps
`default_nettype none

module lcmgr_rma_wiper (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           wipe_en_i,
  input  logic                           disable_i,
  input  logic                           done_i,
  input  logic                           err_i,
  input  logic                           rvalid_i,
  input  logic [lcmgr_pkg::BusWidth-1:0] rdata_i,
  input  logic                           wready_i,
  input  logic [lcmgr_pkg::BusWidth-1:0] rand_i,
  output lcmgr_pkg::flash_req_t          rma_req_o,
  output logic                           wvalid_o,
  output logic [lcmgr_pkg::BusWidth-1:0] wdata_o,
  output logic                           wipe_done_o,
  output logic                           wipe_ok_o
);

  import lcmgr_pkg::*;

  rma_state_e state_q, state_d;

  logic [PageCntW-1:0] page_cnt_q;
  logic [WordCntW-1:0] word_cnt_q;
  logic [BeatW-1:0]    beat_cnt_q;
  logic [ProgBurst-1:0][BusWidth-1:0] prog_data_q;

  logic page_ld, page_incr;
  logic word_clr, word_incr;
  logic beat_clr, prog_en, rd_en;
  logic wr_beat, rd_beat;
  logic err_set, err_q;
  logic done_gap_q;
  logic rma_start;
  flash_op_e rma_op;
  logic [BusAddrW-1:0] rma_addr;

  assign wr_beat = prog_en & wready_i;
  assign rd_beat = rd_en & rvalid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StRmaIdle;
      page_cnt_q <= '0;
      word_cnt_q <= '0;
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
      done_gap_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      // start drops for a cycle after every done
      done_gap_q <= done_i;
      // sticky until reset
      err_q      <= err_q | err_set;

      if (page_ld) begin
        page_cnt_q <= PageCntW'(WipeStartPage);
      end else if (page_incr) begin
        page_cnt_q <= page_cnt_q + 1'b1;
      end

      if (word_clr) begin
        word_cnt_q <= '0;
      end else if (word_incr) begin
        word_cnt_q <= word_cnt_q + WordCntW'(ProgBurst);
      end

      if (beat_clr) begin
        beat_cnt_q <= '0;
      end else if (wr_beat || rd_beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // words of the current burst, kept for the read-back compare
  always_ff @(posedge clk_i) begin
    if (wr_beat) begin
      prog_data_q[beat_cnt_q] <= rand_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // wipe FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    rma_start   = 1'b0;
    rma_op      = FlashOpNone;
    wipe_done_o = 1'b0;
    err_set     = 1'b0;
    page_ld     = 1'b0;
    page_incr   = 1'b0;
    word_clr    = 1'b0;
    word_incr   = 1'b0;
    beat_clr    = 1'b0;
    prog_en     = 1'b0;
    rd_en       = 1'b0;

    case (state_q)
      // disable only lands here, between flash operations
      StRmaIdle: begin
        if (disable_i) begin
          state_d = StRmaDisabled;
        end else if (wipe_en_i) begin
          page_ld = 1'b1;
          state_d = StRmaPageSel;
        end
      end

      StRmaPageSel: begin
        if (disable_i) begin
          state_d = StRmaDisabled;
        end else if (page_cnt_q < PageCntW'(WipeEndPage)) begin
          state_d = StRmaErase;
        end else begin
          wipe_done_o = 1'b1;
          state_d     = StRmaIdle;
        end
      end

      StRmaErase: begin
        rma_start = 1'b1;
        rma_op    = FlashOpErase;
        if (done_i) begin
          err_set = err_i;
          state_d = StRmaEraseWait;
        end
      end

      StRmaEraseWait: begin
        state_d = StRmaWordSel;
      end

      StRmaWordSel: begin
        if (disable_i) begin
          state_d = StRmaDisabled;
        end else if (word_cnt_q < WordCntW'(WordsPerPage)) begin
          state_d = StRmaProgram;
        end else begin
          word_clr  = 1'b1;
          page_incr = 1'b1;
          state_d   = StRmaPageSel;
        end
      end

      StRmaProgram: begin
        rma_start = 1'b1;
        rma_op    = FlashOpProgram;
        prog_en   = 1'b1;
        if ((beat_cnt_q == BeatW'(ProgBurst - 1)) && wready_i) begin
          state_d = StRmaProgramWait;
        end
      end

      StRmaProgramWait: begin
        rma_start = 1'b1;
        rma_op    = FlashOpProgram;
        if (done_i) begin
          beat_clr = 1'b1;
          err_set  = err_i;
          state_d  = StRmaRdVerify;
        end
      end

      StRmaRdVerify: begin
        rma_start = 1'b1;
        rma_op    = FlashOpRead;
        rd_en     = 1'b1;
        err_set   = (rd_beat && (prog_data_q[beat_cnt_q] != rdata_i)) || (done_i && err_i);
        if (done_i) begin
          beat_clr  = 1'b1;
          word_incr = 1'b1;
          state_d   = StRmaWordSel;
        end
      end

      StRmaDisabled: begin
        state_d = StRmaDisabled;
      end

      StRmaInvalid: begin
        err_set = 1'b1;
      end

      default: begin
        state_d = StRmaInvalid;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  // page p, word w sits at p * WordsPerPage + w
  assign rma_addr = BusAddrW'(page_cnt_q) * BusAddrW'(WordsPerPage) + BusAddrW'(word_cnt_q);

  always_comb begin
    rma_req_o.start = rma_start & ~done_gap_q;
    rma_req_o.op    = rma_op;
    rma_req_o.addr  = rma_addr;
    rma_req_o.num   = NumW'(ProgBurst - 1);
  end

  assign wvalid_o  = prog_en;
  assign wdata_o   = rand_i;
  assign wipe_ok_o = ~err_q;

endmodule

`default_nettype wire

// File: design/flash_lcmgr.sv
`timescale 1ns/1ps
`default_nettype none

module flash_lcmgr (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           init_i,
  input  logic                           provision_en_i,
  input  logic                           disable_i,
  input  logic                           rma_req_i,
  input  logic                           done_i,
  input  logic                           err_i,
  input  logic                           rvalid_i,
  input  logic [lcmgr_pkg::BusWidth-1:0] rdata_i,
  input  logic                           wready_i,
  input  logic [lcmgr_pkg::BusWidth-1:0] rand_i,
  output lcmgr_pkg::flash_req_t          flash_req_o,
  output logic                           wvalid_o,
  output logic [lcmgr_pkg::BusWidth-1:0] wdata_o,
  output logic [lcmgr_pkg::NumSeeds-1:0][lcmgr_pkg::SeedReads-1:0][lcmgr_pkg::BusWidth-1:0]
                                         seeds_o,
  output logic                           seed_err_o,
  output logic                           rma_ack_o,
  output logic                           dis_access_o,
  output logic                           fatal_err_o,
  output logic                           init_busy_o,
  output logic                           initialized_o,
  output lcmgr_pkg::lcmgr_phase_e        phase_o
);

  import lcmgr_pkg::*;

  // seed reader side
  flash_req_t seed_req;
  logic       seeds_done;
  logic       seed_run;
  logic       eval_step;

  // wiper side
  flash_req_t rma_req;
  logic       wipe_en;
  logic       wipe_done;
  logic       wipe_ok;

  lcmgr_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .init_i         (init_i),
    .provision_en_i (provision_en_i),
    .disable_i      (disable_i),
    .rma_req_i      (rma_req_i),
    .done_i         (done_i),
    .err_i          (err_i),
    .seed_req_i     (seed_req),
    .seeds_done_i   (seeds_done),
    .rma_req_i_t    (rma_req),
    .wipe_done_i    (wipe_done),
    .wipe_ok_i      (wipe_ok),
    .seed_run_o     (seed_run),
    .eval_step_o    (eval_step),
    .wipe_en_o      (wipe_en),
    .flash_req_o    (flash_req_o),
    .seed_err_o     (seed_err_o),
    .rma_ack_o      (rma_ack_o),
    .dis_access_o   (dis_access_o),
    .fatal_err_o    (fatal_err_o),
    .init_busy_o    (init_busy_o),
    .initialized_o  (initialized_o),
    .phase_o        (phase_o)
  );

  lcmgr_seed_reader u_seed_reader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .seed_run_i   (seed_run),
    .eval_step_i  (eval_step),
    .rvalid_i     (rvalid_i),
    .rdata_i      (rdata_i),
    .seed_req_o   (seed_req),
    .seeds_done_o (seeds_done),
    .seeds_o      (seeds_o)
  );

  lcmgr_rma_wiper u_rma_wiper (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wipe_en_i   (wipe_en),
    .disable_i   (disable_i),
    .done_i      (done_i),
    .err_i       (err_i),
    .rvalid_i    (rvalid_i),
    .rdata_i     (rdata_i),
    .wready_i    (wready_i),
    .rand_i      (rand_i),
    .rma_req_o   (rma_req),
    .wvalid_o    (wvalid_o),
    .wdata_o     (wdata_o),
    .wipe_done_o (wipe_done),
    .wipe_ok_o   (wipe_ok)
  );

endmodule

`default_nettype wire

// File: dv/flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_model (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  lcmgr_pkg::flash_req_t          flash_req_i,
  input  logic                           wvalid_i,
  input  logic [lcmgr_pkg::BusWidth-1:0] wdata_i,
  input  logic                           wready_i,
  input  logic                           inject_err_i,
  input  logic                           corrupt_i,
  output logic                           done_o,
  output logic                           err_o,
  output logic                           rvalid_o,
  output logic [lcmgr_pkg::BusWidth-1:0] rdata_o
);

  import lcmgr_pkg::*;

  localparam int NumWords = 4 * WordsPerPage;
  localparam logic [BusWidth-1:0] SeedFlip = 32'h0f0f_0000;

  logic [BusWidth-1:0] mem [NumWords];
  int   zero_reads;
  logic err_used;
  logic corrupt_used;

  // pattern depends on every address bit
  function automatic logic [BusWidth-1:0] fill_word(input int addr);
    logic [7:0] a;
    a = addr[7:0];
    return {8'hc3 ^ a, 8'h5a + a, ~a, a ^ 8'h96};
  endfunction

  task automatic end_op(input logic fail);
    @(posedge clk_i);
    #1;
    rvalid_o = 1'b0;
    done_o   = 1'b1;
    err_o    = fail;
    @(posedge clk_i);
    #1;
    done_o = 1'b0;
    err_o  = 1'b0;
  endtask

  task automatic run_op(input flash_req_t req);
    int            base;
    int            cnt;
    logic          fail;
    logic [BusWidth-1:0] word;
    base = int'(req.addr);
    cnt  = 0;
    fail = 1'b0;
    case (req.op)
      FlashOpErase: begin
        for (int w = 0; w < WordsPerPage; w++) begin
          mem[(base / WordsPerPage) * WordsPerPage + w] = '1;
        end
        end_op(1'b0);
      end
      FlashOpProgram: begin
        while (cnt <= int'(req.num)) begin
          if (wvalid_i && wready_i) begin
            mem[base + cnt] = wdata_i;
            cnt++;
          end
          if (cnt <= int'(req.num)) begin
            @(negedge clk_i);
          end
        end
        end_op(1'b0);
      end
      FlashOpRead: begin
        fail = inject_err_i && !err_used;
        err_used = err_used | fail;
        for (int i = 0; i <= int'(req.num); i++) begin
          @(posedge clk_i);
          #1;
          word = mem[base + i];
          // second read of seed 0 word 0 comes back with bits flipped
          if (base + i == 0) begin
            zero_reads++;
            if (zero_reads == 2) begin
              word = word ^ SeedFlip;
            end
          end
          if (corrupt_i && !corrupt_used && (base + i >= WipeStartPage * WordsPerPage)) begin
            word[0] = ~word[0];
            corrupt_used = 1'b1;
          end
          rvalid_o = 1'b1;
          rdata_o  = word;
        end
        end_op(fail);
      end
      default: begin
        end_op(1'b1);
      end
    endcase
  endtask

  initial begin
    done_o   = 1'b0;
    err_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        for (int a = 0; a < NumWords; a++) begin
          mem[a] = fill_word(a);
        end
        zero_reads   = 0;
        err_used     = 1'b0;
        corrupt_used = 1'b0;
      end else if (flash_req_i.start) begin
        run_op(flash_req_i);
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/flash_lcmgr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module flash_lcmgr_checker (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    rma_req_i,
  input logic                    rma_ack_i,
  input logic                    dis_access_i,
  input lcmgr_pkg::flash_req_t   flash_req_i,
  input logic                    wiper_idle_i
);

  logic req_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_seen_q <= 1'b0;
    end else if (rma_req_i) begin
      req_seen_q <= 1'b1;
    end
  end

  start_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dis_access_i && wiper_idle_i) |-> !flash_req_i.start)
    else $error("flash request started while access is disabled");

  ack_has_dis: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rma_ack_i |-> dis_access_i)
    else $error("rma ack without access disabled");

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !req_seen_q |-> !rma_ack_i)
    else $error("rma ack before any rma request");

endmodule

bind flash_lcmgr flash_lcmgr_checker u_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .rma_req_i    (rma_req_i),
  .rma_ack_i    (rma_ack_o),
  .dis_access_i (dis_access_o),
  .flash_req_i  (flash_req_o),
  .wiper_idle_i (u_rma_wiper.state_q == lcmgr_pkg::StRmaIdle)
);

`default_nettype wire

// File: dv/flash_lcmgr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module flash_lcmgr_tb;

  import lcmgr_pkg::*;

  typedef logic [NumSeeds-1:0][SeedReads-1:0][BusWidth-1:0] seeds_t;

  typedef struct packed {
    logic   prov;
    logic   rma;
    logic   dis;
    logic   inject;
    logic   corrupt;
    seeds_t seeds;
    logic   seed_err;
    logic   ack;
    logic   dis_access;
    logic   fatal;
    logic   initialized;
  } row_t;

  localparam int NumRows = 6;
  localparam int CyclesPerRow = 3000;
  localparam int WaitLimit = 2000;
  localparam int NumWords = 4 * WordsPerPage;
  localparam logic [BusWidth-1:0] SeedFlip = 32'h0f0f_0000;

  logic clk_i;
  logic rst_ni;
  logic init_i, provision_en_i, disable_i, rma_req_i;
  logic done, err, rvalid, wready_i;
  logic [BusWidth-1:0] rdata, rand_i;
  logic inject_err, corrupt;
  flash_req_t   flash_req;
  logic         wvalid;
  logic [BusWidth-1:0] wdata;
  seeds_t       seeds;
  logic         seed_err, rma_ack, dis_access, fatal_err, init_busy, initialized;
  lcmgr_phase_e phase;

  string names [NumRows];
  row_t  rows [NumRows];
  int    seed = 94756;
  int    errors = 0;
  int    failed_tests = 0;
  logic [BusWidth-1:0] sent_q [$];

  flash_lcmgr uut (
    .clk_i (clk_i), .rst_ni (rst_ni), .init_i (init_i), .provision_en_i (provision_en_i),
    .disable_i (disable_i), .rma_req_i (rma_req_i), .done_i (done), .err_i (err),
    .rvalid_i (rvalid), .rdata_i (rdata), .wready_i (wready_i), .rand_i (rand_i),
    .flash_req_o (flash_req), .wvalid_o (wvalid), .wdata_o (wdata), .seeds_o (seeds),
    .seed_err_o (seed_err), .rma_ack_o (rma_ack), .dis_access_o (dis_access),
    .fatal_err_o (fatal_err), .init_busy_o (init_busy), .initialized_o (initialized),
    .phase_o (phase)
  );

  flash_model u_flash (
    .clk_i (clk_i), .rst_ni (rst_ni), .flash_req_i (flash_req), .wvalid_i (wvalid),
    .wdata_i (wdata), .wready_i (wready_i), .inject_err_i (inject_err),
    .corrupt_i (corrupt), .done_o (done), .err_o (err), .rvalid_o (rvalid),
    .rdata_o (rdata)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // write back-pressure and program data
  always @(posedge clk_i) begin
    #1;
    wready_i = ({$random(seed)} % 3) != 0;
    rand_i   = $random(seed);
  end

  always @(negedge clk_i) begin
    if (rst_ni && wvalid && wready_i) begin
      sent_q.push_back(wdata);
    end
  end

  initial begin
    repeat (NumRows * CyclesPerRow) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, tests did not complete",
             NumRows * CyclesPerRow);
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [BusWidth-1:0] preload_value(input int addr);
    logic [7:0] a;
    a = addr[7:0];
    return {8'hc3 ^ a, 8'h5a + a, ~a, a ^ 8'h96};
  endfunction

  // both reads ANDed, only word 0 of seed 0 differs between reads
  function automatic seeds_t expected_seeds();
    seeds_t s;
    int     addr;
    for (int i = 0; i < NumSeeds; i++) begin
      for (int w = 0; w < SeedReads; w++) begin
        addr = int'(SeedPage[i]) * WordsPerPage + w;
        s[i][w] = preload_value(addr);
        if (addr == 0) begin
          s[i][w] = s[i][w] & (s[i][w] ^ SeedFlip);
        end
      end
    end
    return s;
  endfunction

  function automatic row_t make_row(input logic [4:0] stim, input seeds_t sd,
                                    input logic [4:0] exp);
    row_t r;
    {r.prov, r.rma, r.dis, r.inject, r.corrupt} = stim;
    r.seeds = sd;
    {r.seed_err, r.ack, r.dis_access, r.fatal, r.initialized} = exp;
    return r;
  endfunction

  task automatic compare_value(input string test, input string field,
                               input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %0h actual %0h", test, field, exp, act);
      errors++;
    end
  endtask

  // 0 initialized, 1 ack or access disabled, 2 access disabled
  task automatic wait_event(input int kind, output logic hit);
    int n;
    hit = 1'b0;
    n   = 0;
    while (!hit && n < WaitLimit) begin
      @(negedge clk_i);
      case (kind)
        0:       hit = initialized;
        1:       hit = rma_ack || dis_access;
        default: hit = dis_access;
      endcase
      n++;
    end
  endtask

  task automatic check_memory(input string test);
    logic [BusWidth-1:0] word;
    logic                found;
    int                  page;
    for (int a = 0; a < NumWords; a++) begin
      word = u_flash.mem[a];
      page = a / WordsPerPage;
      if (page >= WipeStartPage && page < WipeStartPage + WipeNumPages) begin
        found = 1'b0;
        foreach (sent_q[k]) begin
          if (sent_q[k] == word) begin
            found = 1'b1;
          end
        end
        if (!found) begin
          $display("%s: wiped word %0d holds %0h, which was never written", test, a, word);
          errors++;
        end
      end else begin
        compare_value(test, $sformatf("mem[%0d]", a), 256'(preload_value(a)), 256'(word));
      end
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   errs_before;
    logic hit;
    r = rows[idx];
    errs_before = errors;
    rst_ni = 1'b0;
    init_i = 1'b0;
    rma_req_i = 1'b0;
    disable_i = 1'b0;
    provision_en_i = r.prov;
    inject_err = r.inject;
    corrupt = r.corrupt;
    sent_q.delete();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    init_i = 1'b1;
    @(posedge clk_i);
    #1;
    init_i = 1'b0;
    // seed phase is busy from the cycle after the strobe
    compare_value(names[idx], "init_busy", 256'(r.prov), 256'(init_busy));
    compare_value(names[idx], "phase", 256'(r.prov ? PhaseSeed : PhaseNone), 256'(phase));
    wait_event(0, hit);
    if (hit && r.rma) begin
      @(posedge clk_i);
      #1;
      rma_req_i = 1'b1;
      @(posedge clk_i);
      #1;
      compare_value(names[idx], "phase", 256'(PhaseRma), 256'(phase));
      wait_event(1, hit);
    end else if (hit && r.dis) begin
      @(posedge clk_i);
      #1;
      disable_i = 1'b1;
      wait_event(2, hit);
    end
    if (!hit) begin
      $display("%s: DUT never reached the expected state", names[idx]);
      errors++;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    compare_value(names[idx], "seeds", 256'(r.seeds), 256'(seeds));
    compare_value(names[idx], "seed_err", 256'(r.seed_err), 256'(seed_err));
    compare_value(names[idx], "rma_ack", 256'(r.ack), 256'(rma_ack));
    compare_value(names[idx], "dis_access", 256'(r.dis_access), 256'(dis_access));
    compare_value(names[idx], "fatal_err", 256'(r.fatal), 256'(fatal_err));
    compare_value(names[idx], "initialized", 256'(r.initialized), 256'(initialized));
    compare_value(names[idx], "init_busy", 256'(1'b0), 256'(init_busy));
    if (r.rma && r.ack) begin
      check_memory(names[idx]);
    end
    if (errors != errs_before) begin
      failed_tests++;
    end
    $display("test %s %s", names[idx], (errors == errs_before) ? "passed" : "failed");
  endtask

  initial begin
    seeds_t good;
    rst_ni = 1'b0;
    init_i = 1'b0;
    provision_en_i = 1'b0;
    disable_i = 1'b0;
    rma_req_i = 1'b0;
    wready_i = 1'b0;
    rand_i = '0;
    inject_err = 1'b0;
    corrupt = 1'b0;
    good = expected_seeds();
    //                   prov rma dis inj cor     err ack dis fat init
    names[0] = "seeds_prov";
    rows[0]  = make_row(5'b10000, good, 5'b00001);
    names[1] = "seeds_off";
    rows[1]  = make_row(5'b00000, '0,   5'b00001);
    names[2] = "seed_err";
    rows[2]  = make_row(5'b10010, good, 5'b10001);
    names[3] = "rma_wipe";
    rows[3]  = make_row(5'b11000, good, 5'b01100);
    names[4] = "rma_corrupt";
    rows[4]  = make_row(5'b11001, good, 5'b00110);
    names[5] = "disable";
    rows[5]  = make_row(5'b10100, good, 5'b00100);
    for (int i = 0; i < NumRows; i++) begin
      run_row(i);
    end
    $display("tests %0d, failed %0d, check errors %0d", NumRows, failed_tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flash_lcmgr.f
design/lcmgr_pkg.sv
design/lcmgr_ctrl.sv
design/lcmgr_seed_reader.sv
design/lcmgr_rma_wiper.sv
design/flash_lcmgr.sv
dv/flash_model.sv
dv/flash_lcmgr_checker.sv
dv/flash_lcmgr_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= flash_lcmgr_tb
FILELIST  ?= flash_lcmgr.f
PASS_MSG  := Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	out="$$(./obj_dir/$(TOP)_sim)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
